/* source/md_pkg.sv */
// Shared definitions for the multiply/divide unit
// Widths, operation codes, request, issue and completion structs

package md_pkg;

  // Operand and result width
  localparam int unsigned xlen = 32;

  // Half-word width used by the multiplier kernel
  localparam int unsigned half_w = 16;

  // Width of the division step counter
  localparam int unsigned step_cnt_w = 5;

  // Operation codes
  typedef enum logic [1:0] {
    MD_OP_MULL = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  // Request as seen on the unit boundary
  // signed_mode[0] marks operand a as signed, signed_mode[1] operand b
  typedef struct packed {
    md_op_e            op;
    logic [1:0]        signed_mode;
    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
  } md_cmd_t;

  // Registered command handed to the engines
  typedef struct packed {
    md_op_e            op;
    logic [xlen-1:0]   op_a;
    logic [xlen-1:0]   op_b;
    // Operand is signed and negative
    logic              neg_a;
    logic              neg_b;
  } md_issue_t;

  // Completion from an engine, valid is a single-cycle pulse
  typedef struct packed {
    logic              valid;
    logic [xlen-1:0]   result;
  } md_done_t;

endpackage

/* source/md_decode.sv */
// Request decode for the multiply/divide unit
// Captures the command, derives operand signs and launches one engine

module md_decode
  import md_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  md_cmd_t   cmd_i,
  input  logic      free_i,
  output md_issue_t issue_o,
  output logic      mult_start_o,
  output logic      div_start_o
);

  logic      busy_q;
  logic      capture;
  logic      cmd_is_mult;
  logic      mult_start_q;
  logic      div_start_q;
  md_issue_t issue_q;

  // New request only counts while no operation is in flight
  assign capture     = req_i & ~busy_q;
  assign cmd_is_mult = (cmd_i.op == MD_OP_MULL) || (cmd_i.op == MD_OP_MULH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      mult_start_q <= 1'b0;
      div_start_q  <= 1'b0;
    end else begin
      // Start pulses follow the capture edge by one cycle
      mult_start_q <= capture & cmd_is_mult;
      div_start_q  <= capture & ~cmd_is_mult;
      if (capture) begin
        busy_q <= 1'b1;
      end else if (free_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Command stays stable from launch until the result stage frees us
  always_ff @(posedge clk_i) begin
    if (capture) begin
      issue_q.op    <= cmd_i.op;
      issue_q.op_a  <= cmd_i.op_a;
      issue_q.op_b  <= cmd_i.op_b;
      issue_q.neg_a <= cmd_i.signed_mode[0] & cmd_i.op_a[xlen-1];
      issue_q.neg_b <= cmd_i.signed_mode[1] & cmd_i.op_b[xlen-1];
    end
  end

  assign issue_o      = issue_q;
  assign mult_start_o = mult_start_q;
  assign div_start_o  = div_start_q;

endmodule

/* source/md_mult_engine.sv */
// Multi-cycle multiplier for MULL and MULH
// One 17x17 signed multiply-accumulate walks the four half-word products

module md_mult_engine
  import md_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  md_issue_t issue_i,
  output md_done_t  done_o
);

  // Accumulator holds a 17x17 product plus carry room
  localparam int unsigned acc_w = 2 * half_w + 2;

  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  mult_state_e       state_q;
  mult_state_e       state_d;
  logic              active_q;
  logic              last_step;
  logic [acc_w-1:0]  acc_q;
  logic [acc_w-1:0]  acc_d;
  logic [acc_w-1:0]  accum;
  logic [acc_w-1:0]  mac_res;
  logic [half_w-1:0] mul_a;
  logic [half_w-1:0] mul_b;
  logic              sgn_a;
  logic              sgn_b;
  logic              acc_ext;
  logic [xlen-1:0]   result;

  // Low 34 bits of the signed product plus accumulator
  assign mac_res = $signed({sgn_a, mul_a}) * $signed({sgn_b, mul_b}) + $signed(accum);

  // Accumulator only goes negative when one of the operands is
  assign acc_ext = (issue_i.neg_a | issue_i.neg_b) & acc_q[acc_w-1];

  always_comb begin
    mul_a     = issue_i.op_a[half_w-1:0];
    mul_b     = issue_i.op_b[half_w-1:0];
    sgn_a     = 1'b0;
    sgn_b     = 1'b0;
    accum     = '0;
    acc_d     = mac_res;
    state_d   = state_q;
    last_step = 1'b0;
    result    = mac_res[xlen-1:0];

    unique case (state_q)
      ALBL: begin
        // al*bl, always unsigned
        state_d = ALBH;
      end
      ALBH: begin
        // al*bh, upper half of b carries its sign
        mul_b = issue_i.op_b[xlen-1:half_w];
        sgn_b = issue_i.neg_b;
        accum = {{(acc_w - half_w){1'b0}}, acc_q[xlen-1:half_w]};
        if (issue_i.op == MD_OP_MULL) begin
          // Keep the finished low half-word below the partial sum
          acc_d = {2'b00, mac_res[half_w-1:0], acc_q[half_w-1:0]};
        end
        state_d = AHBL;
      end
      AHBL: begin
        // ah*bl
        mul_a = issue_i.op_a[xlen-1:half_w];
        sgn_a = issue_i.neg_a;
        if (issue_i.op == MD_OP_MULL) begin
          accum     = {{(acc_w - half_w){1'b0}}, acc_q[xlen-1:half_w]};
          result    = {mac_res[half_w-1:0], acc_q[half_w-1:0]};
          last_step = 1'b1;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        // ah*bh plus the shifted partial sum, MULH only
        mul_a     = issue_i.op_a[xlen-1:half_w];
        mul_b     = issue_i.op_b[xlen-1:half_w];
        sgn_a     = issue_i.neg_a;
        sgn_b     = issue_i.neg_b;
        accum     = {{half_w{acc_ext}}, acc_q[acc_w-1:half_w]};
        last_step = 1'b1;
      end
      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      state_q  <= ALBL;
    end else if (start_i) begin
      active_q <= 1'b1;
      state_q  <= ALBL;
    end else if (active_q) begin
      if (last_step) begin
        active_q <= 1'b0;
        state_q  <= ALBL;
      end else begin
        state_q  <= state_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q) begin
      acc_q <= acc_d;
    end
  end

  assign done_o.valid  = active_q & last_step;
  assign done_o.result = result;

endmodule

/* source/md_div_engine.sv */
// Restoring long divider for DIV and REM
// Absolute values, 32 compare-subtract steps and a final sign fix

module md_div_engine
  import md_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  md_issue_t issue_i,
  output md_done_t  done_o
);

  typedef enum logic [2:0] {
    IDLE, ABS_A, ABS_B, COMP, LAST, CHANGE_SIGN, FINISH
  } div_state_e;

  div_state_e            state_q;
  logic [step_cnt_w-1:0] cnt_q;

  logic [xlen-1:0] numer_q;
  logic [xlen-1:0] denom_q;
  logic [xlen-1:0] quot_q;
  logic [xlen-1:0] rem_q;

  logic [xlen-1:0] sub_a;
  logic [xlen-1:0] sub_b;
  logic [xlen:0]   sub_res;
  logic [xlen:0]   shifted;
  logic            rem_ge;
  logic [xlen-1:0] next_rem;
  logic [xlen-1:0] next_quot;
  logic            is_div;
  logic            change_sign;
  logic [xlen-1:0] fix_val;

  // Single subtractor, carry out set when sub_a >= sub_b
  assign sub_res = {1'b0, sub_a} + {1'b0, ~sub_b} + {{xlen{1'b0}}, 1'b1};

  // Partial remainder shifted left with the next dividend bit
  assign shifted   = {rem_q, numer_q[xlen-1]};
  // Bit 32 set means the shifted value already exceeds any divisor
  assign rem_ge    = shifted[xlen] | sub_res[xlen];
  assign next_rem  = rem_ge ? sub_res[xlen-1:0] : shifted[xlen-1:0];
  assign next_quot = {quot_q[xlen-2:0], rem_ge};

  assign is_div = (issue_i.op == MD_OP_DIV);

  // Quotient is negative when signs differ, remainder follows the dividend
  assign change_sign = is_div ? (issue_i.neg_a ^ issue_i.neg_b) : issue_i.neg_a;
  assign fix_val     = is_div ? quot_q : rem_q;

  // Subtractor operand select, 0 - x gives the negation
  always_comb begin
    sub_a = '0;
    sub_b = issue_i.op_a;
    unique case (state_q)
      ABS_B: begin
        sub_b = issue_i.op_b;
      end
      COMP, LAST: begin
        sub_a = shifted[xlen-1:0];
        sub_b = denom_q;
      end
      CHANGE_SIGN: begin
        sub_b = fix_val;
      end
      default: begin
        sub_b = issue_i.op_a;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start_i) begin
            // Zero divisor skips the whole division
            state_q <= (issue_i.op_b == '0) ? FINISH : ABS_A;
          end
        end
        ABS_A: begin
          state_q <= ABS_B;
        end
        ABS_B: begin
          state_q <= COMP;
          cnt_q   <= '1;
        end
        COMP: begin
          cnt_q <= cnt_q - step_cnt_w'(1);
          if (cnt_q == step_cnt_w'(1)) begin
            state_q <= LAST;
          end
        end
        LAST: begin
          state_q <= CHANGE_SIGN;
        end
        CHANGE_SIGN: begin
          state_q <= FINISH;
        end
        FINISH: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    unique case (state_q)
      IDLE: begin
        // Division by zero result, all ones for DIV, dividend for REM
        if (start_i) begin
          rem_q <= is_div ? '1 : issue_i.op_a;
        end
      end
      ABS_A: begin
        numer_q <= issue_i.neg_a ? sub_res[xlen-1:0] : issue_i.op_a;
      end
      ABS_B: begin
        denom_q <= issue_i.neg_b ? sub_res[xlen-1:0] : issue_i.op_b;
        rem_q   <= '0;
      end
      COMP: begin
        rem_q   <= next_rem;
        quot_q  <= next_quot;
        numer_q <= {numer_q[xlen-2:0], 1'b0};
      end
      LAST: begin
        rem_q  <= next_rem;
        quot_q <= next_quot;
      end
      CHANGE_SIGN: begin
        // Final result lands in the remainder register
        rem_q <= change_sign ? sub_res[xlen-1:0] : fix_val;
      end
      default: begin
        rem_q <= rem_q;
      end
    endcase
  end

  assign done_o.valid  = (state_q == FINISH);
  assign done_o.result = rem_q;

endmodule

/* source/md_result.sv */
// Result stage of the multiply/divide unit
// Holds the finished result and runs the ack side of the handshake

module md_result
  import md_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  md_done_t        mult_done_i,
  input  md_done_t        div_done_i,
  output logic            ack_o,
  output logic [xlen-1:0] result_o,
  output logic            free_o
);

  logic            ack_q;
  logic [xlen-1:0] res_q;
  logic            done_valid;
  logic [xlen-1:0] done_result;
  logic            release_ack;

  // Only one engine can finish at a time
  assign done_valid  = mult_done_i.valid | div_done_i.valid;
  assign done_result = mult_done_i.valid ? mult_done_i.result : div_done_i.result;

  // Requester has dropped req, ack falls on this edge
  assign release_ack = ack_q & ~req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      res_q <= '0;
    end else if (release_ack) begin
      ack_q <= 1'b0;
    end else if (done_valid) begin
      ack_q <= 1'b1;
      res_q <= done_result;
    end
  end

  assign ack_o    = ack_q;
  assign result_o = res_q;
  // Decode leaves busy on the same edge that drops ack
  assign free_o   = release_ack;

endmodule

/* source/md_unit.sv */
// Multiply/divide unit top level
// Decode, multiplier and divider engines, result stage

module md_unit
  import md_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  md_cmd_t         cmd_i,
  output logic            ack_o,
  output logic [xlen-1:0] result_o
);

  md_issue_t issue;
  logic      mult_start;
  logic      div_start;
  md_done_t  mult_done;
  md_done_t  div_done;
  logic      free;

  md_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .cmd_i        (cmd_i),
    .free_i       (free),
    .issue_o      (issue),
    .mult_start_o (mult_start),
    .div_start_o  (div_start)
  );

  md_mult_engine u_mult (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (mult_start),
    .issue_i (issue),
    .done_o  (mult_done)
  );

  md_div_engine u_div (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (div_start),
    .issue_i (issue),
    .done_o  (div_done)
  );

  // Completion is held here until the requester releases it
  md_result u_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .mult_done_i (mult_done),
    .div_done_i  (div_done),
    .ack_o       (ack_o),
    .result_o    (result_o),
    .free_o      (free)
  );

endmodule

/* bench/md_unit_checker.sv */
// Checker for the multiply/divide unit
// Reference model, result compare and four-phase handshake rules

module md_unit_checker
  import md_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            req_i,
  input  md_cmd_t         cmd_i,
  input  logic            ack_i,
  input  logic [xlen-1:0] result_i,
  input  logic            exp_use_i,
  input  logic [xlen-1:0] exp_val_i,
  output int              err_count_o,
  output int              check_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  int              errors = 0;
  int              checked = 0;
  logic            rst_q;
  logic            req_q;
  logic            ack_q;
  logic [xlen-1:0] res_q;
  logic [xlen-1:0] expected_q;
  md_cmd_t         cmd_q;

  // Each operand widened to 64 bits as signed or unsigned by its mode bit
  function automatic logic [xlen-1:0] model_result(input md_cmd_t c);
    logic signed [63:0] a_ext;
    logic signed [63:0] b_ext;
    logic signed [63:0] prod;
    logic [xlen-1:0]    res;
    a_ext = c.signed_mode[0] ? {{32{c.op_a[31]}}, c.op_a} : {32'd0, c.op_a};
    b_ext = c.signed_mode[1] ? {{32{c.op_b[31]}}, c.op_b} : {32'd0, c.op_b};
    prod  = a_ext * b_ext;
    case (c.op)
      MD_OP_MULL: res = prod[31:0];
      MD_OP_MULH: res = prod[63:32];
      // Truncating division, remainder keeps the dividend sign
      MD_OP_DIV:  res = (c.op_b == '0) ? '1 : 32'(a_ext / b_ext);
      default:    res = (c.op_b == '0) ? c.op_a : 32'(a_ext % b_ext);
    endcase
    return res;
  endfunction

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rst_q <= 1'b0;
      req_q <= 1'b0;
      ack_q <= 1'b0;
      res_q <= '0;
    end else begin
      if (!rst_q && (ack_i !== 1'b0 || result_i !== '0)) begin
        errors++;
        $display("ack_o or result_o was not cleared by reset");
      end
      if (req_i && !req_q) begin
        if (ack_i) begin
          errors++;
          $display("req_i rose while ack_o was still high");
        end
        cmd_q      <= cmd_i;
        expected_q <= exp_use_i ? exp_val_i : model_result(cmd_i);
      end
      if (ack_i && !ack_q) begin
        checked++;
        if (result_i !== expected_q) begin
          errors++;
          $display("FAILED result_o op=%0d mode=%b a=%h b=%h expected %h got %h",
                   cmd_q.op, cmd_q.signed_mode, cmd_q.op_a, cmd_q.op_b,
                   expected_q, result_i);
        end
      end
      // Result must hold for the whole ack phase
      if (ack_i && ack_q && result_i !== res_q) begin
        errors++;
        $display("FAILED result_o held %h changed to %h", res_q, result_i);
      end
      if (!ack_i && ack_q && req_q) begin
        errors++;
        $display("ack_o fell while req_i was still high");
      end
      rst_q <= 1'b1;
      req_q <= req_i;
      ack_q <= ack_i;
      res_q <= result_i;
    end
  end

  assign err_count_o   = errors;
  assign check_count_o = checked;

endmodule

/* bench/md_unit_tb.sv */
// Testbench top for the multiply/divide unit
// Clock, reset, directed table, random requests and four-phase requester

module md_unit_tb
  import md_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_vec  = 19;
  localparam int n_rand = 40;

  typedef struct packed {
    md_cmd_t         cmd;
    logic [xlen-1:0] exp;
  } vec_t;

  // op, signed mode, a, b, expected result
  vec_t vectors [n_vec] = '{
    {MD_OP_MULL, 2'b11, 32'h0000_0007, 32'h0000_0006, 32'h0000_002a},
    {MD_OP_MULL, 2'b11, 32'hffff_ffff, 32'h0000_0005, 32'hffff_fffb},
    {MD_OP_MULL, 2'b00, 32'h0001_0001, 32'hffff_0000, 32'hffff_0000},
    {MD_OP_MULH, 2'b00, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe},
    {MD_OP_MULH, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000},
    {MD_OP_MULH, 2'b01, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff},
    {MD_OP_MULH, 2'b10, 32'h8000_0000, 32'hffff_fffe, 32'hffff_ffff},
    {MD_OP_MULH, 2'b11, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
    {MD_OP_DIV,  2'b11, 32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd},
    {MD_OP_REM,  2'b11, 32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff},
    {MD_OP_DIV,  2'b00, 32'hffff_fff9, 32'h0000_0002, 32'h7fff_fffc},
    {MD_OP_REM,  2'b00, 32'hffff_fff9, 32'h0000_0002, 32'h0000_0001},
    {MD_OP_DIV,  2'b11, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000},
    {MD_OP_REM,  2'b11, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000},
    {MD_OP_DIV,  2'b11, 32'h0000_0064, 32'h0000_0000, 32'hffff_ffff},
    {MD_OP_REM,  2'b11, 32'hffff_ff9c, 32'h0000_0000, 32'hffff_ff9c},
    {MD_OP_DIV,  2'b11, 32'h0000_0007, 32'hffff_fffe, 32'hffff_fffd},
    {MD_OP_DIV,  2'b00, 32'h8000_0001, 32'h0000_0000, 32'hffff_ffff},
    {MD_OP_REM,  2'b10, 32'h8000_0001, 32'h0000_0000, 32'h8000_0001}
  };

  logic            clk_i = 1'b0;
  logic            rst_ni;
  logic            req_i;
  md_cmd_t         cmd_i;
  logic            ack_o;
  logic [xlen-1:0] result_o;
  logic            exp_use;
  logic [xlen-1:0] exp_val;
  int              err_count;
  int              check_count;
  int              timeouts = 0;
  logic [31:0]     seed = 32'hf76e_7e2e;
  logic [31:0]     ctl;
  md_cmd_t         rand_cmd;

  always #10 clk_i = ~clk_i;

  md_unit dut0 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .cmd_i    (cmd_i),
    .ack_o    (ack_o),
    .result_o (result_o)
  );

  md_unit_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .cmd_i         (cmd_i),
    .ack_i         (ack_o),
    .result_i      (result_o),
    .exp_use_i     (exp_use),
    .exp_val_i     (exp_val),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // One full four-phase transfer with hold extra cycles of back-pressure
  task automatic run_request(input md_cmd_t cmd, input logic use_exp,
                             input logic [xlen-1:0] exp, input int hold);
    int waited;
    @(posedge clk_i);
    req_i   <= 1'b1;
    cmd_i   <= cmd;
    exp_use <= use_exp;
    exp_val <= exp;
    waited = 0;
    while (ack_o !== 1'b1 && waited < 100) begin
      @(posedge clk_i);
      waited++;
    end
    if (ack_o !== 1'b1) begin
      timeouts++;
      $display("Timeout: ack_o did not rise within 100 cycles");
    end
    repeat (hold) @(posedge clk_i);
    req_i <= 1'b0;
    waited = 0;
    while (ack_o !== 1'b0 && waited < 100) begin
      @(posedge clk_i);
      waited++;
    end
    if (ack_o !== 1'b0) begin
      timeouts++;
      $display("Timeout: ack_o did not fall within 100 cycles");
    end
  endtask

  initial begin
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    cmd_i   = '0;
    exp_use = 1'b0;
    exp_val = '0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < n_vec && timeouts == 0; i++) begin
      run_request(vectors[i].cmd, 1'b1, vectors[i].exp, i % 3);
    end

    for (int i = 0; i < n_rand && timeouts == 0; i++) begin
      seed = xorshift32(seed);
      ctl  = seed;
      seed = xorshift32(seed);
      rand_cmd.op_a = seed;
      seed = xorshift32(seed);
      rand_cmd.op_b = seed;
      // Bias some divisors to zero or to small values
      if (ctl[7:4] == 4'd0) begin
        rand_cmd.op_b = '0;
      end else if (ctl[7:4] == 4'd1) begin
        rand_cmd.op_b = {28'd0, ctl[11:8]};
      end
      rand_cmd.op          = md_op_e'(ctl[1:0]);
      rand_cmd.signed_mode = ctl[3:2];
      run_request(rand_cmd, 1'b0, '0, int'(ctl[14:12]));
    end

    repeat (2) @(posedge clk_i);
    if (timeouts == 0 && check_count != n_vec + n_rand) begin
      $display("Only %0d of %0d results were compared", check_count, n_vec + n_rand);
    end
    $display("Summary: %0d errors, %0d timeouts, %0d results compared",
             err_count, timeouts, check_count);
    if (err_count == 0 && timeouts == 0 && check_count == n_vec + n_rand) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* md_unit.f */
source/md_pkg.sv
source/md_decode.sv
source/md_mult_engine.sv
source/md_div_engine.sv
source/md_result.sv
source/md_unit.sv
bench/md_unit_checker.sv
bench/md_unit_tb.sv
